// File: hw/pad_ctrl_pkg.sv
`default_nettype none

package pad_ctrl_pkg;

  // source select per pad
  typedef enum logic [1:0] {
    PAD_SEL_PERIO  = 2'd0,
    PAD_SEL_APBIO  = 2'd1,
    PAD_SEL_FPGAIO = 2'd2,
    // pad left undriven, out 0 and oe 0
    PAD_SEL_NONE   = 2'd3
  } pad_sel_t;

  // drive strength, pulls etc, opaque to this block
  typedef logic [5:0] pad_cfg_t;

  // apb widths
  localparam int APB_ADDR_W = 12;
  localparam int APB_DATA_W = 32;

  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;

  // address map
  //   [11:9] reserved, must be zero
  //   [8]    bank, 0 = select, 1 = config
  //   [7:2]  pad index
  //   [1:0]  byte offset, ignored
  localparam int BANK_SEL_BIT = 8;
  localparam int IDX_LSB      = 2;

  // width of the pad index field
  localparam int PAD_IDX_W    = BANK_SEL_BIT - IDX_LSB;

  // first reserved address bit
  localparam int RSVD_LSB     = BANK_SEL_BIT + 1;

  // max pads addressable by the index field
  localparam int MAX_IO       = 1 << PAD_IDX_W;

endpackage

`default_nettype wire

// File: hw/pad_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module pad_reg_bank
  import pad_ctrl_pkg::*;
#(
  parameter int  N_IO    = 16,
  parameter type field_t = logic
) (
  input  logic                 ref_clk_i,
  input  logic                 arst_n_i,
  // write port
  input  logic                 we_i,
  input  logic [PAD_IDX_W-1:0] widx_i,
  input  field_t               wdata_i,
  // read port
  input  logic [PAD_IDX_W-1:0] ridx_i,
  output field_t               rdata_o,
  // whole array for the pad logic
  output field_t [N_IO-1:0]    fields_o
);

  field_t [N_IO-1:0] fields_q;

  logic widx_ok;
  logic ridx_ok;

  // indices past the last pad hit nothing
  assign widx_ok = int'(widx_i) < N_IO;
  assign ridx_ok = int'(ridx_i) < N_IO;

  always_ff @(posedge ref_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < N_IO; i++) begin
        fields_q[i] <= field_t'(0);
      end
    end else if (we_i && widx_ok) begin
      fields_q[widx_i] <= wdata_i;
    end
  end

  always_comb begin
    rdata_o = field_t'(0);
    if (ridx_ok) begin
      rdata_o = fields_q[ridx_i];
    end
  end

  assign fields_o = fields_q;

endmodule

`default_nettype wire

// File: hw/pad_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module pad_cfg_regs
  import pad_ctrl_pkg::*;
#(
  parameter int N_IO = 16
) (
  input  logic                  ref_clk_i,
  input  logic                  arst_n_i,
  // apb slave
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  apb_addr_t             paddr_i,
  input  apb_data_t             pwdata_i,
  output apb_data_t             prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  // register contents
  output pad_sel_t [N_IO-1:0]   sel_o,
  output pad_cfg_t [N_IO-1:0]   cfg_o
);

  localparam int SEL_W = $bits(pad_sel_t);
  localparam int CFG_W = $bits(pad_cfg_t);

  logic                 access;
  logic                 bank_cfg;
  logic [PAD_IDX_W-1:0] idx;
  logic                 rsvd_err;
  logic                 idx_err;
  logic                 addr_err;
  logic                 acc_ok;
  logic                 sel_we;
  logic                 cfg_we;
  pad_sel_t             sel_rdata;
  pad_cfg_t             cfg_rdata;

  // access phase only, setup phase is ignored
  assign access   = psel_i & penable_i;

  assign bank_cfg = paddr_i[BANK_SEL_BIT];
  assign idx      = paddr_i[IDX_LSB +: PAD_IDX_W];

  assign rsvd_err = |paddr_i[APB_ADDR_W-1:RSVD_LSB];
  assign idx_err  = int'(idx) >= N_IO;
  assign addr_err = rsvd_err | idx_err;
  assign acc_ok   = access & ~addr_err;

  // at most one bank written per access
  assign sel_we   = acc_ok & pwrite_i & ~bank_cfg;
  assign cfg_we   = acc_ok & pwrite_i & bank_cfg;

  pad_reg_bank #(
    .N_IO    (N_IO),
    .field_t (pad_sel_t)
  ) u_sel_bank (
    .ref_clk_i (ref_clk_i),
    .arst_n_i  (arst_n_i),
    .we_i      (sel_we),
    .widx_i    (idx),
    .wdata_i   (pad_sel_t'(pwdata_i[SEL_W-1:0])),
    .ridx_i    (idx),
    .rdata_o   (sel_rdata),
    .fields_o  (sel_o)
  );

  pad_reg_bank #(
    .N_IO    (N_IO),
    .field_t (pad_cfg_t)
  ) u_cfg_bank (
    .ref_clk_i (ref_clk_i),
    .arst_n_i  (arst_n_i),
    .we_i      (cfg_we),
    .widx_i    (idx),
    .wdata_i   (pad_cfg_t'(pwdata_i[CFG_W-1:0])),
    .ridx_i    (idx),
    .rdata_o   (cfg_rdata),
    .fields_o  (cfg_o)
  );

  // read data, zero extended, 0 on error
  always_comb begin
    prdata_o = '0;
    if (acc_ok && !pwrite_i) begin
      if (bank_cfg) begin
        prdata_o[CFG_W-1:0] = cfg_rdata;
      end else begin
        prdata_o[SEL_W-1:0] = sel_rdata;
      end
    end
  end

  // no wait states
  assign pready_o  = access;
  assign pslverr_o = access & addr_err;

endmodule

`default_nettype wire

// File: hw/pad_mux.sv
`timescale 1ns/1ps
`default_nettype none

module pad_mux
  import pad_ctrl_pkg::*;
#(
  parameter int N_IO = 16
) (
  input  pad_sel_t [N_IO-1:0] sel_i,
  // peripheral io
  input  logic [N_IO-1:0]     perio_out_i,
  input  logic [N_IO-1:0]     perio_oe_i,
  output logic [N_IO-1:0]     perio_in_o,
  // apb gpio
  input  logic [N_IO-1:0]     apbio_out_i,
  input  logic [N_IO-1:0]     apbio_oe_i,
  output logic [N_IO-1:0]     apbio_in_o,
  // fabric io
  input  logic [N_IO-1:0]     fpgaio_out_i,
  input  logic [N_IO-1:0]     fpgaio_oe_i,
  output logic [N_IO-1:0]     fpgaio_in_o,
  // towards the pins
  input  logic [N_IO-1:0]     func_in_i,
  output logic [N_IO-1:0]     func_out_o,
  output logic [N_IO-1:0]     func_oe_o
);

  always_comb begin
    func_out_o  = '0;
    func_oe_o   = '0;
    perio_in_o  = '0;
    apbio_in_o  = '0;
    fpgaio_in_o = '0;
    for (int k = 0; k < N_IO; k++) begin
      case (sel_i[k])
        PAD_SEL_PERIO: begin
          func_out_o[k] = perio_out_i[k];
          func_oe_o[k]  = perio_oe_i[k];
          perio_in_o[k] = func_in_i[k];
        end
        PAD_SEL_APBIO: begin
          func_out_o[k] = apbio_out_i[k];
          func_oe_o[k]  = apbio_oe_i[k];
          apbio_in_o[k] = func_in_i[k];
        end
        PAD_SEL_FPGAIO: begin
          func_out_o[k]  = fpgaio_out_i[k];
          func_oe_o[k]   = fpgaio_oe_i[k];
          fpgaio_in_o[k] = func_in_i[k];
        end
        // none: pad stays off, no source sees the input
        default: begin
          func_out_o[k] = 1'b0;
          func_oe_o[k]  = 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/stm_pad_override.sv
`timescale 1ns/1ps
`default_nettype none

module stm_pad_override #(
  parameter int N_IO      = 16,
  parameter int TEST_BASE = 4,
  parameter int N_TEST    = 4
) (
  input  logic              stm_i,
  // from the pad mux
  input  logic [N_IO-1:0]   func_out_i,
  input  logic [N_IO-1:0]   func_oe_i,
  output logic [N_IO-1:0]   func_in_o,
  // fabric test port
  input  logic [N_TEST-1:0] test_out_i,
  input  logic [N_TEST-1:0] test_oe_i,
  output logic [N_TEST-1:0] test_in_o,
  // pins
  input  logic [N_IO-1:0]   io_in_i,
  output logic [N_IO-1:0]   io_out_o,
  output logic [N_IO-1:0]   io_oe_o
);

  // window has to fit in the pad ring
  if (TEST_BASE + N_TEST > N_IO) begin : g_bad_window
    $error("test window %0d+%0d exceeds %0d pads", TEST_BASE, N_TEST, N_IO);
  end

  always_comb begin
    if (stm_i) begin
      // everything off, then open the window
      io_out_o = '0;
      io_oe_o  = '0;
      for (int k = 0; k < N_TEST; k++) begin
        io_out_o[TEST_BASE+k] = test_out_i[k];
        io_oe_o[TEST_BASE+k]  = test_oe_i[k];
      end
    end else begin
      io_out_o = func_out_i;
      io_oe_o  = func_oe_i;
    end
  end

  // functional inputs are blocked in test mode
  assign func_in_o = stm_i ? '0 : io_in_i;

  // test pad k carries test bit k
  assign test_in_o = stm_i ? io_in_i[TEST_BASE +: N_TEST] : '0;

endmodule

`default_nettype wire

// File: hw/mcu_pad_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_pad_ctrl
  import pad_ctrl_pkg::*;
#(
  parameter int N_IO      = 16,
  parameter int TEST_BASE = 4,
  parameter int N_TEST    = 4
) (
  input  logic                ref_clk_i,
  input  logic                arst_n_i,
  // apb slave
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  apb_addr_t           paddr_i,
  input  apb_data_t           pwdata_i,
  output apb_data_t           prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  // test mode
  input  logic                stm_i,
  // pads
  input  logic [N_IO-1:0]     io_in_i,
  output logic [N_IO-1:0]     io_out_o,
  output logic [N_IO-1:0]     io_oe_o,
  output pad_cfg_t [N_IO-1:0] pad_cfg_o,
  // peripheral io
  input  logic [N_IO-1:0]     perio_out_i,
  input  logic [N_IO-1:0]     perio_oe_i,
  output logic [N_IO-1:0]     perio_in_o,
  // apb gpio
  input  logic [N_IO-1:0]     apbio_out_i,
  input  logic [N_IO-1:0]     apbio_oe_i,
  output logic [N_IO-1:0]     apbio_in_o,
  // fabric io
  input  logic [N_IO-1:0]     fpgaio_out_i,
  input  logic [N_IO-1:0]     fpgaio_oe_i,
  output logic [N_IO-1:0]     fpgaio_in_o,
  // fabric test port
  input  logic [N_TEST-1:0]   test_out_i,
  input  logic [N_TEST-1:0]   test_oe_i,
  output logic [N_TEST-1:0]   test_in_o
);

  pad_sel_t [N_IO-1:0] sel_q;
  pad_cfg_t [N_IO-1:0] cfg_q;

  // functional side of the override
  logic [N_IO-1:0]     func_out;
  logic [N_IO-1:0]     func_oe;
  logic [N_IO-1:0]     func_in;

  pad_cfg_regs #(
    .N_IO (N_IO)
  ) u_regs (
    .ref_clk_i (ref_clk_i),
    .arst_n_i  (arst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .sel_o     (sel_q),
    .cfg_o     (cfg_q)
  );

  // pad config goes straight out, test mode does not touch it
  assign pad_cfg_o = cfg_q;

  pad_mux #(
    .N_IO (N_IO)
  ) u_mux (
    .sel_i        (sel_q),
    .perio_out_i  (perio_out_i),
    .perio_oe_i   (perio_oe_i),
    .perio_in_o   (perio_in_o),
    .apbio_out_i  (apbio_out_i),
    .apbio_oe_i   (apbio_oe_i),
    .apbio_in_o   (apbio_in_o),
    .fpgaio_out_i (fpgaio_out_i),
    .fpgaio_oe_i  (fpgaio_oe_i),
    .fpgaio_in_o  (fpgaio_in_o),
    .func_in_i    (func_in),
    .func_out_o   (func_out),
    .func_oe_o    (func_oe)
  );

  stm_pad_override #(
    .N_IO      (N_IO),
    .TEST_BASE (TEST_BASE),
    .N_TEST    (N_TEST)
  ) u_stm (
    .stm_i      (stm_i),
    .func_out_i (func_out),
    .func_oe_i  (func_oe),
    .func_in_o  (func_in),
    .test_out_i (test_out_i),
    .test_oe_i  (test_oe_i),
    .test_in_o  (test_in_o),
    .io_in_i    (io_in_i),
    .io_out_o   (io_out_o),
    .io_oe_o    (io_oe_o)
  );

endmodule

`default_nettype wire

// File: dv/mcu_pad_ctrl_chk.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_pad_ctrl_chk #(
  parameter int N_IO      = 16,
  parameter int TEST_BASE = 4,
  parameter int N_TEST    = 4
) (
  input  logic              ref_clk_i,
  input  logic              arst_n_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pready_i,
  input  logic              pslverr_i,
  input  logic              stm_i,
  input  logic [N_IO-1:0]   io_oe_i,
  input  logic [N_TEST-1:0] test_in_i
);

  localparam logic [N_IO-1:0] WIN_ONES = {N_TEST{1'b1}};
  localparam logic [N_IO-1:0] WIN_MASK = WIN_ONES << TEST_BASE;

  // failed assertions so far
  int unsigned fail_cnt = 0;

  // every access completes in its first access cycle
  a_pready_in_access: assert property (@(posedge ref_clk_i) disable iff (!arst_n_i)
    (psel_i && penable_i) |-> pready_i)
    else begin
      $error("pready low during an access cycle");
      fail_cnt++;
    end

  // also covers reset
  a_no_err_outside_access: assert property (@(posedge ref_clk_i)
    !(psel_i && penable_i) |-> !pslverr_i)
    else begin
      $error("pslverr high outside an access cycle");
      fail_cnt++;
    end

  a_stm_drivers_off: assert property (@(posedge ref_clk_i) disable iff (!arst_n_i)
    stm_i |-> ((io_oe_i & ~WIN_MASK) == '0))
    else begin
      $error("pad driver on outside the test window in test mode");
      fail_cnt++;
    end

  a_test_in_idle: assert property (@(posedge ref_clk_i) disable iff (!arst_n_i)
    !stm_i |-> (test_in_i == '0))
    else begin
      $error("test port input active in functional mode");
      fail_cnt++;
    end

endmodule

bind mcu_pad_ctrl mcu_pad_ctrl_chk #(
  .N_IO      (N_IO),
  .TEST_BASE (TEST_BASE),
  .N_TEST    (N_TEST)
) u_chk (
  .ref_clk_i (ref_clk_i),
  .arst_n_i  (arst_n_i),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pready_i  (pready_o),
  .pslverr_i (pslverr_o),
  .stm_i     (stm_i),
  .io_oe_i   (io_oe_o),
  .test_in_i (test_in_o)
);

`default_nettype wire

// File: dv/tb_mcu_pad_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mcu_pad_ctrl
  import pad_ctrl_pkg::*;
();

  localparam int N_IO       = 16;
  localparam int TEST_BASE  = 4;
  localparam int N_TEST     = 4;
  // tests take about 600 cycles
  localparam int MAX_CYCLES = 2000;

  logic ref_clk;
  logic arst_n;
  logic psel;
  logic penable;
  logic pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic pready;
  logic pslverr;
  logic stm;
  logic [N_IO-1:0] io_in, io_out, io_oe;
  pad_cfg_t [N_IO-1:0] pad_cfg;
  logic [N_IO-1:0] perio_out, perio_oe, perio_in;
  logic [N_IO-1:0] apbio_out, apbio_oe, apbio_in;
  logic [N_IO-1:0] fpgaio_out, fpgaio_oe, fpgaio_in;
  logic [N_TEST-1:0] test_out, test_oe, test_in;

  // shadow of the register file
  pad_sel_t sel_shadow [N_IO];
  pad_cfg_t cfg_shadow [N_IO];

  logic [31:0] rng_state;
  logic checking;
  logic exp_err;
  apb_data_t exp_rdata;
  int cycle_cnt;

  mcu_pad_ctrl u_dut (
    .ref_clk_i    (ref_clk),
    .arst_n_i     (arst_n),
    .psel_i       (psel),
    .penable_i    (penable),
    .pwrite_i     (pwrite),
    .paddr_i      (paddr),
    .pwdata_i     (pwdata),
    .prdata_o     (prdata),
    .pready_o     (pready),
    .pslverr_o    (pslverr),
    .stm_i        (stm),
    .io_in_i      (io_in),
    .io_out_o     (io_out),
    .io_oe_o      (io_oe),
    .pad_cfg_o    (pad_cfg),
    .perio_out_i  (perio_out),
    .perio_oe_i   (perio_oe),
    .perio_in_o   (perio_in),
    .apbio_out_i  (apbio_out),
    .apbio_oe_i   (apbio_oe),
    .apbio_in_o   (apbio_in),
    .fpgaio_out_i (fpgaio_out),
    .fpgaio_oe_i  (fpgaio_oe),
    .fpgaio_in_o  (fpgaio_in),
    .test_out_i   (test_out),
    .test_oe_i    (test_oe),
    .test_in_o    (test_in)
  );

  initial begin
    ref_clk = 1'b0;
    forever #50 ref_clk = ~ref_clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:16]) % n;
  endfunction

  function automatic logic [N_IO-1:0] rand_vec();
    logic [31:0] r;
    r = next_rand();
    return r[31 -: N_IO];
  endfunction

  // expected pins and source inputs
  function automatic void ref_route(output logic [N_IO-1:0] out, oe, p_in, a_in, f_in,
                                    output logic [N_TEST-1:0] t_in);
    out = '0;
    oe = '0;
    p_in = '0;
    a_in = '0;
    f_in = '0;
    t_in = '0;
    for (int k = 0; k < N_IO; k++) begin
      if (stm) begin
        if (k >= TEST_BASE && k < TEST_BASE + N_TEST) begin
          out[k] = test_out[k-TEST_BASE];
          oe[k] = test_oe[k-TEST_BASE];
          t_in[k-TEST_BASE] = io_in[k];
        end
      end else if (sel_shadow[k] == PAD_SEL_PERIO) begin
        out[k] = perio_out[k];
        oe[k] = perio_oe[k];
        p_in[k] = io_in[k];
      end else if (sel_shadow[k] == PAD_SEL_APBIO) begin
        out[k] = apbio_out[k];
        oe[k] = apbio_oe[k];
        a_in[k] = io_in[k];
      end else if (sel_shadow[k] == PAD_SEL_FPGAIO) begin
        out[k] = fpgaio_out[k];
        oe[k] = fpgaio_oe[k];
        f_in[k] = io_in[k];
      end
    end
  endfunction

  task automatic fail_stop();
    $display("Done: errors found");
    $fatal(1, "stopping on the first error");
  endtask

  task automatic check_pads(input string name, input logic [N_IO-1:0] exp,
                            input logic [N_IO-1:0] act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %h actual %h", $time, name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_cfg(input string name, input pad_cfg_t exp, input pad_cfg_t act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %h actual %h", $time, name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_rdata(input string name, input apb_data_t exp, input apb_data_t act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %h actual %h", $time, name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %b actual %b", $time, name, exp, act);
      fail_stop();
    end
  endtask

  // compare at the falling edge where inputs are stable
  always @(negedge ref_clk) begin : compare
    logic [N_IO-1:0] e_out, e_oe, e_pin, e_ain, e_fin;
    logic [N_TEST-1:0] e_tin;
    if (u_dut.u_chk.fail_cnt != 0) begin
      $display("an assertion of the bound checker failed before %0t", $time);
      fail_stop();
    end
    if (checking) begin
      ref_route(e_out, e_oe, e_pin, e_ain, e_fin, e_tin);
      check_pads("io_out_o", e_out, io_out);
      check_pads("io_oe_o", e_oe, io_oe);
      check_pads("perio_in_o", e_pin, perio_in);
      check_pads("apbio_in_o", e_ain, apbio_in);
      check_pads("fpgaio_in_o", e_fin, fpgaio_in);
      check_pads("test_in_o", N_IO'(e_tin), N_IO'(test_in));
      for (int k = 0; k < N_IO; k++) begin
        check_cfg($sformatf("pad_cfg_o[%0d]", k), cfg_shadow[k], pad_cfg[k]);
      end
      check_bit("pready_o", psel & penable, pready);
      check_bit("pslverr_o", psel & penable & exp_err, pslverr);
      // reads return data, errors return 0 for reads and writes
      if (psel && penable && (!pwrite || exp_err)) begin
        check_rdata("prdata_o", exp_rdata, prdata);
      end
    end
  end

  always @(posedge ref_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      fail_stop();
    end
  end

  // one setup and one access cycle entered 1 ns after a rising edge
  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata);
    int idx;
    logic err;
    idx = int'(addr[IDX_LSB +: PAD_IDX_W]);
    err = (addr[APB_ADDR_W-1:RSVD_LSB] != '0) || (idx >= N_IO);
    psel = 1'b1;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    exp_err = err;
    exp_rdata = '0;
    if (!err && addr[BANK_SEL_BIT]) begin
      exp_rdata[5:0] = cfg_shadow[idx];
    end else if (!err) begin
      exp_rdata[1:0] = sel_shadow[idx];
    end
    @(posedge ref_clk);
    #1;
    penable = 1'b1;
    @(posedge ref_clk);
    #1;
    if (wr && !err && addr[BANK_SEL_BIT]) begin
      cfg_shadow[idx] = wdata[5:0];
    end else if (wr && !err) begin
      sel_shadow[idx] = pad_sel_t'(wdata[1:0]);
    end
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    exp_err = 1'b0;
  endtask

  function automatic apb_addr_t make_addr(input logic bank, input int idx);
    apb_addr_t a;
    a = '0;
    a[BANK_SEL_BIT] = bank;
    a[IDX_LSB +: PAD_IDX_W] = idx[PAD_IDX_W-1:0];
    return a;
  endfunction

  task automatic read_all();
    for (int b = 0; b < 2; b++) begin
      for (int k = 0; k < N_IO; k++) begin
        apb_access(1'b0, make_addr(b[0], k), '0);
      end
    end
  endtask

  task automatic idle_random(input int n);
    repeat (n) begin
      perio_out = rand_vec();
      perio_oe = rand_vec();
      apbio_out = rand_vec();
      apbio_oe = rand_vec();
      fpgaio_out = rand_vec();
      fpgaio_oe = rand_vec();
      io_in = rand_vec();
      test_out = rand_vec();
      test_oe = rand_vec();
      @(posedge ref_clk);
      #1;
    end
  endtask

  initial begin : main
    apb_addr_t a;
    {arst_n, psel, penable, pwrite, stm, checking, exp_err} = '0;
    {paddr, pwdata, exp_rdata, io_in, test_out, test_oe} = '0;
    {perio_out, perio_oe, apbio_out, apbio_oe, fpgaio_out, fpgaio_oe} = '0;
    cycle_cnt = 0;
    rng_state = 32'h595c_460a;
    for (int k = 0; k < N_IO; k++) begin
      sel_shadow[k] = PAD_SEL_PERIO;
      cfg_shadow[k] = '0;
    end
    repeat (10) @(posedge ref_clk);
    #1;
    arst_n = 1'b1;
    checking = 1'b1;
    // reset values with all pads on perio
    idle_random(8);
    read_all();
    // random writes then full readback
    repeat (24) begin
      apb_access(1'b1, make_addr(rand_below(2) == 1, rand_below(N_IO)), next_rand());
    end
    read_all();
    // bad index and reserved bits
    repeat (8) begin
      a = make_addr(rand_below(2) == 1, N_IO + rand_below(MAX_IO - N_IO));
      apb_access(1'b1, a, next_rand());
      apb_access(1'b0, a, '0);
      a = make_addr(rand_below(2) == 1, rand_below(N_IO));
      a[APB_ADDR_W-1:RSVD_LSB] = 3'(1 + rand_below(7));
      apb_access(rand_below(2) == 1, a, next_rand());
    end
    read_all();
    // random routing including PAD_SEL_NONE
    repeat (3) begin
      for (int k = 0; k < N_IO; k++) begin
        apb_access(1'b1, make_addr(1'b0, k), next_rand());
      end
      idle_random(40);
    end
    // test mode takeover and release
    stm = 1'b1;
    idle_random(30);
    stm = 1'b0;
    idle_random(10);
    if (u_dut.u_chk.fail_cnt != 0) begin
      $display("an assertion of the bound checker failed");
      fail_stop();
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: mcu_pad_ctrl.f
hw/pad_ctrl_pkg.sv
hw/pad_reg_bank.sv
hw/pad_cfg_regs.sv
hw/pad_mux.sv
hw/stm_pad_override.sv
hw/mcu_pad_ctrl.sv
dv/mcu_pad_ctrl_chk.sv
dv/tb_mcu_pad_ctrl.sv
